// ==== hw/datapath_defs.svh ====
`ifndef DATAPATH_DEFS_SVH
`define DATAPATH_DEFS_SVH

// data path widths
`define DP_WORD_WIDTH 32
`define DP_NUM_REGS   16
`define DP_OP_WIDTH   5
`define DP_SEL_WIDTH  5

// alu op codes
// any other code gives a zero result
`define DP_OP_ADD  5'd3
`define DP_OP_SUB  5'd4
`define DP_OP_SHR  5'd5
`define DP_OP_SHRA 5'd6
`define DP_OP_SHL  5'd7
`define DP_OP_ROR  5'd8
`define DP_OP_ROL  5'd9
`define DP_OP_AND  5'd10
`define DP_OP_OR   5'd11
`define DP_OP_NEG  5'd17
`define DP_OP_NOT  5'd18

// bus source code n selects general register n
`define DP_SRC_R0   5'd0
`define DP_SRC_R1   5'd1
`define DP_SRC_R2   5'd2
`define DP_SRC_R3   5'd3
`define DP_SRC_R4   5'd4
`define DP_SRC_R5   5'd5
`define DP_SRC_R6   5'd6
`define DP_SRC_R7   5'd7
`define DP_SRC_R8   5'd8
`define DP_SRC_R9   5'd9
`define DP_SRC_R10  5'd10
`define DP_SRC_R11  5'd11
`define DP_SRC_R12  5'd12
`define DP_SRC_R13  5'd13
`define DP_SRC_R14  5'd14
`define DP_SRC_R15  5'd15
`define DP_SRC_ZHI  5'd16
`define DP_SRC_ZLO  5'd17
`define DP_SRC_PC   5'd18
`define DP_SRC_MDR  5'd19
`define DP_SRC_NONE 5'd31

`endif

// ==== hw/datapath_pkg.sv ====
`default_nettype none

`include "datapath_defs.svh"

package datapath_pkg;

    // one bus word
    typedef logic [`DP_WORD_WIDTH-1:0] word_t;

    // full alu result, high word then low word
    typedef logic [2*`DP_WORD_WIDTH-1:0] wide_t;

    typedef logic [`DP_OP_WIDTH-1:0] op_code_t;

    // encoded bus source
    typedef logic [`DP_SEL_WIDTH-1:0] bus_sel_t;

    // one bit per general register
    typedef logic [`DP_NUM_REGS-1:0] reg_mask_t;

endpackage

`default_nettype wire

// ==== hw/register_file.sv ====
`default_nettype none

`include "datapath_defs.svh"

module register_file (
    input  logic                  clk,
    input  logic                  reset,
    input  datapath_pkg::reg_mask_t reg_in,
    input  datapath_pkg::word_t     bus_data,
    output datapath_pkg::word_t     reg_data [`DP_NUM_REGS]
);

    import datapath_pkg::*;

    word_t regs [`DP_NUM_REGS];

    // several registers may take the same bus value in one cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `DP_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `DP_NUM_REGS; i++) begin
                if (reg_in[i]) begin
                    regs[i] <= bus_data;
                end
            end
        end
    end

    // read side goes straight to the bus mux
    always_comb begin
        for (int i = 0; i < `DP_NUM_REGS; i++) begin
            reg_data[i] = regs[i];
        end
    end

endmodule

`default_nettype wire

// ==== hw/special_registers.sv ====
`default_nettype none

module special_registers (
    input  logic                clk,
    input  logic                reset,
    input  datapath_pkg::word_t bus_data,
    input  datapath_pkg::wide_t alu_result,
    input  logic                y_enable,
    input  logic                z_enable,
    input  logic                pc_enable,
    input  logic                pc_increment,
    input  logic                mar_enable,
    input  logic                mdr_enable,
    input  logic                read,
    input  datapath_pkg::word_t m_data_in,
    output datapath_pkg::word_t y_data,
    output datapath_pkg::word_t zhi_data,
    output datapath_pkg::word_t zlo_data,
    output datapath_pkg::word_t pc_data,
    output datapath_pkg::word_t mar_data,
    output datapath_pkg::word_t mdr_data
);

    import datapath_pkg::*;

    word_t mdr_next;

    // memory side wins when a read is in progress
    assign mdr_next = read ? m_data_in : bus_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            y_data   <= '0;
            zhi_data <= '0;
            zlo_data <= '0;
            mar_data <= '0;
            mdr_data <= '0;
        end else begin
            if (y_enable) begin
                y_data <= bus_data;
            end
            // Z keeps both halves of the alu result
            if (z_enable) begin
                {zhi_data, zlo_data} <= alu_result;
            end
            if (mar_enable) begin
                mar_data <= bus_data;
            end
            if (mdr_enable) begin
                mdr_data <= mdr_next;
            end
        end
    end

    // load beats increment
    always_ff @(posedge clk) begin
        if (reset) begin
            pc_data <= '0;
        end else if (pc_enable) begin
            pc_data <= bus_data;
        end else if (pc_increment) begin
            pc_data <= pc_data + word_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== hw/alu.sv ====
`default_nettype none

`include "datapath_defs.svh"

module alu (
    input  datapath_pkg::op_code_t op_code,
    input  datapath_pkg::word_t    a,
    input  datapath_pkg::word_t    b,
    output datapath_pkg::wide_t    result
);

    import datapath_pkg::*;

    logic [`DP_WORD_WIDTH:0]       sum;
    logic [`DP_WORD_WIDTH:0]       diff;
    logic [4:0]                    amount;
    logic [2*`DP_WORD_WIDTH-1:0]   doubled;
    logic [2*`DP_WORD_WIDTH-1:0]   rot_right;
    logic [2*`DP_WORD_WIDTH-1:0]   rot_left;
    word_t                         low_word;
    logic                          carry_bit;

    // extra top bit holds carry or borrow
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    // shift amount is the low five bits of the bus operand
    assign amount = b[4:0];

    // rotate by shifting a doubled copy of the operand
    assign doubled   = {a, a};
    assign rot_right = doubled >> amount;
    assign rot_left  = doubled << amount;

    always_comb begin
        low_word  = '0;
        carry_bit = 1'b0;
        case (op_code)
            `DP_OP_ADD: begin
                low_word  = sum[`DP_WORD_WIDTH-1:0];
                carry_bit = sum[`DP_WORD_WIDTH];
            end
            `DP_OP_SUB: begin
                low_word  = diff[`DP_WORD_WIDTH-1:0];
                carry_bit = diff[`DP_WORD_WIDTH];
            end
            `DP_OP_AND:  low_word = a & b;
            `DP_OP_OR:   low_word = a | b;
            `DP_OP_NOT:  low_word = ~b;
            `DP_OP_NEG:  low_word = -b;
            `DP_OP_SHR:  low_word = a >> amount;
            // arithmetic shift keeps the sign
            `DP_OP_SHRA: low_word = word_t'($signed(a) >>> amount);
            `DP_OP_SHL:  low_word = a << amount;
            `DP_OP_ROR:  low_word = rot_right[`DP_WORD_WIDTH-1:0];
            `DP_OP_ROL:  low_word = rot_left[2*`DP_WORD_WIDTH-1:`DP_WORD_WIDTH];
            default: begin
                low_word  = '0;
                carry_bit = 1'b0;
            end
        endcase
    end

    // high word only carries the add/sub carry in bit 0
    assign result = {{(`DP_WORD_WIDTH-1){1'b0}}, carry_bit, low_word};

endmodule

`default_nettype wire

// ==== hw/bus_select.sv ====
`default_nettype none

`include "datapath_defs.svh"

module bus_select (
    input  datapath_pkg::reg_mask_t reg_out,
    input  logic                    zhi_out,
    input  logic                    zlo_out,
    input  logic                    pc_out,
    input  logic                    mdr_out,
    input  datapath_pkg::word_t     reg_data [`DP_NUM_REGS],
    input  datapath_pkg::word_t     zhi_data,
    input  datapath_pkg::word_t     zlo_data,
    input  datapath_pkg::word_t     pc_data,
    input  datapath_pkg::word_t     mdr_data,
    output datapath_pkg::word_t     bus_data
);

    import datapath_pkg::*;

    localparam int NUM_SRC = `DP_NUM_REGS + 4;

    logic [NUM_SRC-1:0] strobes;
    bus_sel_t           select;

    // bit position matches the source code
    assign strobes = {mdr_out, pc_out, zlo_out, zhi_out, reg_out};

    // scan from the top so the lowest asserted source is left last
    always_comb begin
        select = `DP_SRC_NONE;
        for (int i = NUM_SRC - 1; i >= 0; i--) begin
            if (strobes[i]) begin
                select = bus_sel_t'(i);
            end
        end
    end

    always_comb begin
        case (select)
            `DP_SRC_ZHI:  bus_data = zhi_data;
            `DP_SRC_ZLO:  bus_data = zlo_data;
            `DP_SRC_PC:   bus_data = pc_data;
            `DP_SRC_MDR:  bus_data = mdr_data;
            `DP_SRC_NONE: bus_data = '0;
            default: begin
                // codes below 16 are the general registers
                if (select < `DP_SRC_ZHI) begin
                    bus_data = reg_data[select[3:0]];
                end else begin
                    bus_data = '0;
                end
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/datapath.sv ====
`default_nettype none

`include "datapath_defs.svh"

module datapath (
    input  logic                    clk,
    input  logic                    reset,
    input  datapath_pkg::reg_mask_t reg_in,
    input  datapath_pkg::reg_mask_t reg_out,
    input  logic                    pc_out,
    input  logic                    zhi_out,
    input  logic                    zlo_out,
    input  logic                    mdr_out,
    input  logic                    y_enable,
    input  logic                    z_enable,
    input  logic                    pc_enable,
    input  logic                    pc_increment,
    input  logic                    mar_enable,
    input  logic                    mdr_enable,
    input  logic                    read,
    input  datapath_pkg::op_code_t  op_code,
    input  datapath_pkg::word_t     m_data_in,
    output datapath_pkg::word_t     bus_data,
    output datapath_pkg::word_t     mar_data,
    output datapath_pkg::word_t     mdr_data
);

    import datapath_pkg::*;

    word_t reg_data [`DP_NUM_REGS];
    word_t y_data;
    word_t zhi_data;
    word_t zlo_data;
    word_t pc_data;
    wide_t alu_result;

    register_file i_register_file (
        .clk      (clk),
        .reset    (reset),
        .reg_in   (reg_in),
        .bus_data (bus_data),
        .reg_data (reg_data)
    );

    special_registers i_special_registers (
        .clk          (clk),
        .reset        (reset),
        .bus_data     (bus_data),
        .alu_result   (alu_result),
        .y_enable     (y_enable),
        .z_enable     (z_enable),
        .pc_enable    (pc_enable),
        .pc_increment (pc_increment),
        .mar_enable   (mar_enable),
        .mdr_enable   (mdr_enable),
        .read         (read),
        .m_data_in    (m_data_in),
        .y_data       (y_data),
        .zhi_data     (zhi_data),
        .zlo_data     (zlo_data),
        .pc_data      (pc_data),
        .mar_data     (mar_data),
        .mdr_data     (mdr_data)
    );

    // Y is operand a, the bus is operand b
    alu i_alu (
        .op_code (op_code),
        .a       (y_data),
        .b       (bus_data),
        .result  (alu_result)
    );

    // only driver of the shared bus
    bus_select i_bus_select (
        .reg_out  (reg_out),
        .zhi_out  (zhi_out),
        .zlo_out  (zlo_out),
        .pc_out   (pc_out),
        .mdr_out  (mdr_out),
        .reg_data (reg_data),
        .zhi_data (zhi_data),
        .zlo_data (zlo_data),
        .pc_data  (pc_data),
        .mdr_data (mdr_data),
        .bus_data (bus_data)
    );

endmodule

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // reset held over the first cycles
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule

`default_nettype wire

// ==== test/datapath_tb.sv ====
`default_nettype none

`include "datapath_defs.svh"

module datapath_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import datapath_pkg::*;

    // a register move may read back all sixteen targets
    localparam int TEST_CYCLES = 8 + 21 + 200 * 18 + 300 * 6 + 100 + 200 + 100 * 2;
    localparam int CYCLE_LIMIT = TEST_CYCLES + 100;

    logic      clk;
    logic      reset;
    reg_mask_t reg_in;
    reg_mask_t reg_out;
    logic      pc_out, zhi_out, zlo_out, mdr_out;
    logic      y_enable, z_enable, pc_enable, pc_increment;
    logic      mar_enable, mdr_enable, read;
    op_code_t  op_code;
    word_t     m_data_in;
    word_t     bus_data;
    word_t     mar_data;
    word_t     mdr_data;

    // reference copies of every register
    word_t m_regs [`DP_NUM_REGS];
    word_t m_y, m_zhi, m_zlo, m_pc, m_mar, m_mdr;

    logic [31:0] lfsr = 32'ha29b;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          test_start = 0;
    int          k;
    word_t       value;
    reg_mask_t   mask;
    op_code_t    valid_ops [11] = '{`DP_OP_ADD, `DP_OP_SUB, `DP_OP_AND, `DP_OP_OR,
        `DP_OP_NOT, `DP_OP_NEG, `DP_OP_SHR, `DP_OP_SHRA, `DP_OP_SHL, `DP_OP_ROR, `DP_OP_ROL};

    tb_clock i_clock (
        .clk   (clk),
        .reset (reset)
    );

    datapath i_dut (.*);

    // galois lfsr stepped once per bit
    function automatic logic rand_bit();
        lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
        return lfsr[0];
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    function automatic wide_t model_alu(input op_code_t op, input word_t a, input word_t b);
        word_t      lo;
        logic       c;
        logic [4:0] n;
        lo = '0;
        c = 1'b0;
        n = b[4:0];
        case (op)
            // carry out when the sum wraps below an operand
            `DP_OP_ADD: begin
                lo = a + b;
                c = lo < a;
            end
            // borrow when the subtrahend is larger
            `DP_OP_SUB: begin
                lo = a - b;
                c = a < b;
            end
            `DP_OP_AND:  lo = a & b;
            `DP_OP_OR:   lo = a | b;
            `DP_OP_NOT:  lo = ~b;
            `DP_OP_NEG:  lo = ~b + 32'd1;
            `DP_OP_SHR:  lo = a >> n;
            `DP_OP_SHRA: lo = $signed(a) >>> n;
            `DP_OP_SHL:  lo = a << n;
            // a shift by 32 is zero, so n of 0 needs no special case
            `DP_OP_ROR:  lo = (a >> n) | (a << (6'd32 - {1'b0, n}));
            `DP_OP_ROL:  lo = (a << n) | (a >> (6'd32 - {1'b0, n}));
            default:     lo = '0;
        endcase
        return {31'd0, c, lo};
    endfunction

    // lowest source code wins
    function automatic word_t model_bus();
        logic  found;
        word_t v;
        found = 1'b0;
        v = '0;
        for (int i = 0; i < `DP_NUM_REGS; i++) begin
            if (reg_out[i] && !found) begin
                v = m_regs[i];
                found = 1'b1;
            end
        end
        if (!found) begin
            v = zhi_out ? m_zhi : zlo_out ? m_zlo : pc_out ? m_pc : mdr_out ? m_mdr : '0;
        end
        return v;
    endfunction

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        assert (actual === expected) else begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h",
                $time, name, expected, actual);
            errors++;
        end
    endtask

    task automatic clear_controls();
        reg_in <= '0;
        reg_out <= '0;
        {pc_out, zhi_out, zlo_out, mdr_out} <= '0;
        {y_enable, z_enable, pc_enable, pc_increment} <= '0;
        {mar_enable, mdr_enable, read} <= '0;
        op_code <= '0;
        m_data_in <= '0;
    endtask

    task automatic begin_cycle();
        @(posedge clk);
        clear_controls();
    endtask

    // check mid cycle, then advance the model past the coming edge
    task automatic end_cycle();
        word_t bus;
        wide_t alu_out;
        @(negedge clk);
        bus = model_bus();
        check_word("bus_data", bus, bus_data);
        check_word("mar_data", m_mar, mar_data);
        check_word("mdr_data", m_mdr, mdr_data);
        alu_out = model_alu(op_code, m_y, bus);
        for (int i = 0; i < `DP_NUM_REGS; i++) begin
            if (reg_in[i]) m_regs[i] = bus;
        end
        if (y_enable) m_y = bus;
        if (z_enable) {m_zhi, m_zlo} = alu_out;
        if (pc_enable) m_pc = bus;
        else if (pc_increment) m_pc = m_pc + 32'd1;
        if (mar_enable) m_mar = bus;
        if (mdr_enable) m_mdr = read ? m_data_in : bus;
    endtask

    task automatic load_mdr(input word_t data);
        begin_cycle();
        mdr_enable <= 1'b1;
        read <= 1'b1;
        m_data_in <= data;
        end_cycle();
    endtask

    task automatic report_test(input string name);
        $display("test %s done, %0d errors", name, errors - test_start);
        test_start = errors;
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: simulation did not finish");
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        clear_controls();
        for (int i = 0; i < `DP_NUM_REGS; i++) begin
            m_regs[i] = '0;
        end
        {m_y, m_zhi, m_zlo, m_pc, m_mar, m_mdr} = '0;
        @(negedge reset);

        // every source reads zero out of reset
        begin_cycle();
        end_cycle();
        for (int i = 0; i < 20; i++) begin
            begin_cycle();
            if (i < 16) reg_out <= reg_mask_t'(1) << i;
            else {mdr_out, pc_out, zlo_out, zhi_out} <= 4'b0001 << (i - 16);
            end_cycle();
            check_word("bus_data after reset", '0, bus_data);
        end
        report_test("reset");

        for (int n = 0; n < 200; n++) begin
            value = rand_bits(32);
            mask = reg_mask_t'(rand_bits(16));
            load_mdr(value);
            begin_cycle();
            mdr_out <= 1'b1;
            reg_in <= mask;
            end_cycle();
            for (int i = 0; i < `DP_NUM_REGS; i++) begin
                if (mask[i]) begin
                    begin_cycle();
                    reg_out <= reg_mask_t'(1) << i;
                    end_cycle();
                    check_word("bus_data readback", value, bus_data);
                end
            end
        end
        report_test("register transfers");

        // Y first, then b on the bus into Z, then both halves read out
        for (int n = 0; n < 300; n++) begin
            load_mdr(rand_bits(32));
            begin_cycle();
            mdr_out <= 1'b1;
            y_enable <= 1'b1;
            end_cycle();
            load_mdr(rand_bits(32));
            begin_cycle();
            mdr_out <= 1'b1;
            z_enable <= 1'b1;
            k = int'(rand_bits(4)) % 11;
            op_code <= rand_bit() ? valid_ops[k] : op_code_t'(rand_bits(5));
            end_cycle();
            begin_cycle();
            zlo_out <= 1'b1;
            end_cycle();
            begin_cycle();
            zhi_out <= 1'b1;
            end_cycle();
        end
        report_test("alu");

        // every eighth case leaves the bus undriven
        for (int n = 0; n < 100; n++) begin
            begin_cycle();
            if (n % 8 != 0) begin
                reg_out <= rand_bit() ? reg_mask_t'(rand_bits(16)) : '0;
                {zhi_out, zlo_out, pc_out, mdr_out} <= 4'(rand_bits(4));
            end
            end_cycle();
        end
        report_test("bus priority");

        for (int n = 0; n < 200; n++) begin
            k = int'(rand_bits(4));
            begin_cycle();
            if (rand_bit()) reg_out <= reg_mask_t'(1) << k;
            else pc_out <= 1'b1;
            pc_enable <= rand_bit();
            pc_increment <= rand_bit();
            mar_enable <= rand_bit();
            end_cycle();
        end
        report_test("pc and mar");

        for (int n = 0; n < 100; n++) begin
            k = int'(rand_bits(4));
            begin_cycle();
            reg_out <= reg_mask_t'(1) << k;
            mdr_enable <= 1'b1;
            end_cycle();
            begin_cycle();
            end_cycle();
            check_word("mdr_data write path", m_regs[k], mdr_data);
        end
        report_test("mdr write");

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+hw
hw/datapath_pkg.sv
hw/register_file.sv
hw/special_registers.sv
hw/alu.sv
hw/bus_select.sv
hw/datapath.sv
test/tb_clock.sv
test/datapath_tb.sv

// ==== Makefile ====
TOP = datapath_tb

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) \
		-f verilog.f -o sim

run: compile
	./obj_dir/sim > run.log 2>&1; cat run.log
	grep -q "No errors" run.log

clean:
	rm -rf obj_dir run.log

.PHONY: all compile run clean
